/* common/bomb_pkg.sv */
// ---------------------------------------------------------------------------
// Shared types for the bomb subsystem
// ---------------------------------------------------------------------------
package bomb_pkg;

  // Map geometry, 11 rows by 19 columns fit in 4 + 5 bits
  localparam int ROW_BITS  = 4;               // Up to 16 rows
  localparam int COL_BITS  = 5;               // Up to 32 columns
  localparam int ADDR_BITS = ROW_BITS + COL_BITS;

  // Row and column fields of a tile address
  typedef struct packed {
    logic [ROW_BITS-1:0] row;                 // Upper field
    logic [COL_BITS-1:0] col;                 // Lower field
  } tile_rc_t;

  // Tile address word
  // The word is {row, col} and not row * NUM_COL + col, so both views
  // name the same tile and a step to the left never wraps into the
  // previous row
  typedef union packed {
    logic [ADDR_BITS-1:0] flat;               // Whole word for equality
    tile_rc_t             rc;                 // Fields for adjacency
  } tile_addr_t;

  // Per-bomb slot states
  typedef enum logic [1:0] {
    SLOT_IDLE  = 2'd0,                        // No bomb held
    SLOT_FUSE  = 2'd1,                        // Bomb placed, fuse burning
    SLOT_BLAST = 2'd2,                        // Explosion on screen
    SLOT_FREE  = 2'd3                         // One cycle, clear the blocks
  } slot_state_t;

endpackage

/* bomb/bomb_dispatch.sv */
`timescale 1ns/1ps

// ---------------------------------------------------------------------------
// Placement dispatcher
// Arms the lowest idle slot, answers every request with ack or drop
// ---------------------------------------------------------------------------
module bomb_dispatch #(
  parameter int NUM_SLOTS = 4,
  parameter int NUM_ROW   = 11,
  parameter int NUM_COL   = 19
) (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  place_req,   // One-cycle strobe
  input  bomb_pkg::tile_addr_t                  place_addr,  // Valid with place_req
  input  logic                 [NUM_SLOTS-1:0]  slot_busy,
  input  bomb_pkg::tile_addr_t [NUM_SLOTS-1:0]  slot_addr,
  output logic                 [NUM_SLOTS-1:0]  arm,         // One-hot pulse
  output bomb_pkg::tile_addr_t                  arm_addr,
  output logic                                  place_ack,
  output logic                                  place_drop
);

  logic [NUM_SLOTS-1:0] pick;        // Lowest idle slot, one-hot
  logic                 have_free;   // At least one slot idle
  logic                 dup_hit;     // Tile already holds a bomb
  logic                 in_range;    // Tile lies on the map
  logic                 accept;

  // Lowest idle slot wins
  always_comb begin
    pick      = '0;
    have_free = 1'b0;
    for (int i = 0; i < NUM_SLOTS; i++) begin
      if (!slot_busy[i] && !have_free) begin
        pick[i]   = 1'b1;
        have_free = 1'b1;
      end
    end
  end

  // Duplicate test against busy slots only, idle slots hold stale tiles
  always_comb begin
    dup_hit = 1'b0;
    for (int i = 0; i < NUM_SLOTS; i++) begin
      if (slot_busy[i] && (slot_addr[i].flat == place_addr.flat)) begin
        dup_hit = 1'b1;
      end
    end
  end

  assign in_range = (place_addr.rc.row < NUM_ROW) &&
                    (place_addr.rc.col < NUM_COL);

  assign accept = place_req && have_free && !dup_hit && in_range;

  // Arm goes straight to the slot so it enters FUSE on the same edge
  // that raises place_ack
  assign arm      = accept ? pick : '0;
  assign arm_addr = place_addr;

  // -------------------------------------------------------------------------
  // Answer to the request, one cycle later
  // -------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      place_ack  <= 1'b0;
      place_drop <= 1'b0;
    end else begin
      place_ack  <= accept;
      place_drop <= place_req && !accept;  // Full, duplicate or off map
    end
  end

endmodule

/* bomb/bomb_slot.sv */
`timescale 1ns/1ps

// ---------------------------------------------------------------------------
// One bomb slot
// IDLE -> FUSE -> BLAST -> FREE -> IDLE, timed in ticks
// ---------------------------------------------------------------------------
module bomb_slot #(
  parameter int FUSE_TICKS  = 3,
  parameter int BLAST_TICKS = 2
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  tick,       // Time-base pulse
  input  logic                  arm,        // Start a bomb on arm_addr
  input  bomb_pkg::tile_addr_t  arm_addr,
  output logic                  slot_busy,  // Any state but IDLE
  output bomb_pkg::tile_addr_t  slot_addr,  // Tile of the held bomb
  output logic                  blast,      // High through BLAST
  output logic                  free        // One cycle in FREE
);

  localparam int MAX_TICKS = (FUSE_TICKS > BLAST_TICKS) ? FUSE_TICKS : BLAST_TICKS;
  localparam int CNT_BITS  = $clog2(MAX_TICKS + 1);

  localparam logic [CNT_BITS-1:0] FUSE_LAST  = CNT_BITS'(FUSE_TICKS - 1);
  localparam logic [CNT_BITS-1:0] BLAST_LAST = CNT_BITS'(BLAST_TICKS - 1);

  bomb_pkg::slot_state_t st;
  bomb_pkg::slot_state_t nst;
  logic [CNT_BITS-1:0]   tick_cnt;    // Ticks taken in this state
  bomb_pkg::tile_addr_t  addr_q;

  // -------------------------------------------------------------------------
  // Next state
  // -------------------------------------------------------------------------
  always_comb begin
    nst = st;  // Hold by default
    case (st)
      bomb_pkg::SLOT_IDLE: begin
        if (arm) nst = bomb_pkg::SLOT_FUSE;
      end
      bomb_pkg::SLOT_FUSE: begin
        if (tick && (tick_cnt == FUSE_LAST)) nst = bomb_pkg::SLOT_BLAST;
      end
      bomb_pkg::SLOT_BLAST: begin
        if (tick && (tick_cnt == BLAST_LAST)) nst = bomb_pkg::SLOT_FREE;
      end
      bomb_pkg::SLOT_FREE: nst = bomb_pkg::SLOT_IDLE;  // Single cycle
      default:             nst = bomb_pkg::SLOT_IDLE;
    endcase
  end

  // State and tick counter
  always_ff @(posedge clk) begin
    if (rst) begin
      st       <= bomb_pkg::SLOT_IDLE;
      tick_cnt <= '0;
    end else begin
      st <= nst;
      if (st != nst) begin
        tick_cnt <= '0;                    // Fresh count per state
      end else if (tick && ((st == bomb_pkg::SLOT_FUSE) ||
                            (st == bomb_pkg::SLOT_BLAST))) begin
        tick_cnt <= tick_cnt + 1'b1;
      end
    end
  end

  // Tile latched on arm, kept through FREE for the collector
  always_ff @(posedge clk) begin
    if ((st == bomb_pkg::SLOT_IDLE) && arm) begin
      addr_q <= arm_addr;
    end
  end

  // -------------------------------------------------------------------------
  // Outputs
  // -------------------------------------------------------------------------
  assign slot_busy = (st != bomb_pkg::SLOT_IDLE);
  assign slot_addr = addr_q;
  assign blast     = (st == bomb_pkg::SLOT_BLAST);
  assign free      = (st == bomb_pkg::SLOT_FREE);

endmodule

/* bomb/blast_collect.sv */
`timescale 1ns/1ps

// ---------------------------------------------------------------------------
// Blast collector
// Serializes clear requests and flags player contact with any blast
// ---------------------------------------------------------------------------
module blast_collect #(
  parameter int NUM_SLOTS  = 4,
  parameter int TILE_SHIFT = 6,   // log2 of tile size in pixels
  parameter int SPRITE_W   = 32,
  parameter int SPRITE_H   = 48
) (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                 [NUM_SLOTS-1:0]  blast,
  input  logic                 [NUM_SLOTS-1:0]  free,
  input  bomb_pkg::tile_addr_t [NUM_SLOTS-1:0]  slot_addr,
  input  logic                 [10:0]           player_x,   // Pixels
  input  logic                 [9:0]            player_y,   // Pixels
  output logic                                  clear_req,  // One-cycle strobe
  output bomb_pkg::tile_addr_t                  clear_addr,
  output logic                                  game_over,
  output logic                                  exploding
);

  // -------------------------------------------------------------------------
  // Clear request queue, one flag and one tile per slot
  // -------------------------------------------------------------------------
  logic                 [NUM_SLOTS-1:0] pend;
  bomb_pkg::tile_addr_t [NUM_SLOTS-1:0] pend_addr;
  logic                 [NUM_SLOTS-1:0] req_vec;
  logic                 [NUM_SLOTS-1:0] sel;        // Issued this cycle
  logic                                 any_req;
  bomb_pkg::tile_addr_t                 sel_addr;

  // A slot in FREE competes in the same cycle, lowest index first
  always_comb begin
    req_vec  = pend | free;
    sel      = '0;
    any_req  = 1'b0;
    sel_addr = '0;
    for (int i = 0; i < NUM_SLOTS; i++) begin
      if (req_vec[i] && !any_req) begin
        sel[i]   = 1'b1;
        any_req  = 1'b1;
        sel_addr = pend[i] ? pend_addr[i] : slot_addr[i];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pend      <= '0;
      clear_req <= 1'b0;
    end else begin
      clear_req <= any_req;
      for (int i = 0; i < NUM_SLOTS; i++) begin
        if (sel[i]) pend[i] <= 1'b0;       // Issued now
        else if (free[i]) pend[i] <= 1'b1; // Lost arbitration, wait
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < NUM_SLOTS; i++) begin
      if (free[i]) pend_addr[i] <= slot_addr[i];
    end
    if (any_req) clear_addr <= sel_addr;
  end

  // -------------------------------------------------------------------------
  // Player tiles, top-left plus straddled neighbours
  // -------------------------------------------------------------------------
  logic [10:0]                   px_tile;
  logic [9:0]                    py_tile;
  logic [bomb_pkg::ROW_BITS-1:0] prow;
  logic [bomb_pkg::COL_BITS-1:0] pcol;
  logic                          x_str;      // Sprite crosses into next column
  logic                          y_str;      // Sprite crosses into next row
  bomb_pkg::tile_addr_t [3:0]    cov;
  logic                 [3:0]    cov_ok;
  logic                          hit;

  assign px_tile = player_x >> TILE_SHIFT;
  assign py_tile = player_y >> TILE_SHIFT;
  assign pcol    = px_tile[bomb_pkg::COL_BITS-1:0];
  assign prow    = py_tile[bomb_pkg::ROW_BITS-1:0];

  assign x_str = (int'(player_x[TILE_SHIFT-1:0]) + SPRITE_W) > (1 << TILE_SHIFT);
  assign y_str = (int'(player_y[TILE_SHIFT-1:0]) + SPRITE_H) > (1 << TILE_SHIFT);

  assign cov[0].flat = {prow,        pcol};
  assign cov[1].flat = {prow + 1'b1, pcol};
  assign cov[2].flat = {prow,        pcol + 1'b1};
  assign cov[3].flat = {prow + 1'b1, pcol + 1'b1};
  assign cov_ok      = {x_str && y_str, x_str, y_str, 1'b1};

  // Same row within one column, or same column within one row
  function automatic logic in_cross(input bomb_pkg::tile_addr_t t,
                                    input bomb_pkg::tile_addr_t b);
    int dr;
    int dc;
    dr = int'(t.rc.row) - int'(b.rc.row);
    dc = int'(t.rc.col) - int'(b.rc.col);
    return ((dr == 0) && (dc >= -1) && (dc <= 1)) ||
           ((dc == 0) && (dr >= -1) && (dr <= 1));
  endfunction

  always_comb begin
    hit = 1'b0;
    for (int s = 0; s < NUM_SLOTS; s++) begin
      for (int k = 0; k < 4; k++) begin
        if (blast[s] && cov_ok[k] && in_cross(cov[k], slot_addr[s])) hit = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) game_over <= 1'b0;
    else     game_over <= hit;   // Previous cycle's contact
  end

  assign exploding = |blast;

endmodule

/* logic/bomb_field.sv */
`timescale 1ns/1ps

// ---------------------------------------------------------------------------
// Bomb subsystem top
// Dispatcher, a row of bomb slots and the blast collector
// ---------------------------------------------------------------------------
module bomb_field #(
  parameter int NUM_SLOTS   = 4,
  parameter int FUSE_TICKS  = 3,
  parameter int BLAST_TICKS = 2,
  parameter int NUM_ROW     = 11,
  parameter int NUM_COL     = 19,
  parameter int TILE_SHIFT  = 6,    // 64-pixel tiles
  parameter int SPRITE_W    = 32,
  parameter int SPRITE_H    = 48
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  tick,
  input  logic                  place_req,
  input  bomb_pkg::tile_addr_t  place_addr,
  input  logic [10:0]           player_x,
  input  logic [9:0]            player_y,
  output logic                  place_ack,
  output logic                  place_drop,
  output logic                  clear_req,
  output bomb_pkg::tile_addr_t  clear_addr,
  output logic                  game_over,
  output logic                  exploding
);

  logic                 [NUM_SLOTS-1:0] arm;
  bomb_pkg::tile_addr_t                 arm_addr;   // Shared by all slots
  logic                 [NUM_SLOTS-1:0] slot_busy;
  bomb_pkg::tile_addr_t [NUM_SLOTS-1:0] slot_addr;
  logic                 [NUM_SLOTS-1:0] blast;
  logic                 [NUM_SLOTS-1:0] free;

  bomb_dispatch #(
    .NUM_SLOTS (NUM_SLOTS),
    .NUM_ROW   (NUM_ROW),
    .NUM_COL   (NUM_COL)
  ) i_dispatch (
    .clk        (clk),
    .rst        (rst),
    .place_req  (place_req),
    .place_addr (place_addr),
    .slot_busy  (slot_busy),
    .slot_addr  (slot_addr),
    .arm        (arm),
    .arm_addr   (arm_addr),
    .place_ack  (place_ack),
    .place_drop (place_drop)
  );

  // One slot per bomb in flight
  for (genvar g = 0; g < NUM_SLOTS; g++) begin : g_slot
    bomb_slot #(
      .FUSE_TICKS  (FUSE_TICKS),
      .BLAST_TICKS (BLAST_TICKS)
    ) i_slot (
      .clk       (clk),
      .rst       (rst),
      .tick      (tick),
      .arm       (arm[g]),
      .arm_addr  (arm_addr),
      .slot_busy (slot_busy[g]),
      .slot_addr (slot_addr[g]),
      .blast     (blast[g]),
      .free      (free[g])
    );
  end

  blast_collect #(
    .NUM_SLOTS  (NUM_SLOTS),
    .TILE_SHIFT (TILE_SHIFT),
    .SPRITE_W   (SPRITE_W),
    .SPRITE_H   (SPRITE_H)
  ) i_collect (
    .clk        (clk),
    .rst        (rst),
    .blast      (blast),
    .free       (free),
    .slot_addr  (slot_addr),
    .player_x   (player_x),
    .player_y   (player_y),
    .clear_req  (clear_req),
    .clear_addr (clear_addr),
    .game_over  (game_over),
    .exploding  (exploding)
  );

endmodule

/* testbench/bomb_field_chk.sv */
`timescale 1ns/1ps

// ---------------------------------------------------------------------------
// Protocol checks on the bomb subsystem ports
// ---------------------------------------------------------------------------
module bomb_field_chk #(
  parameter int NUM_SLOTS = 4
) (
  input logic                 clk,
  input logic                 rst,
  input logic                 place_req,
  input logic                 place_ack,
  input logic                 place_drop,
  input logic                 clear_req,
  input logic                 game_over,
  input logic                 exploding,
  input logic [NUM_SLOTS-1:0] free        // Slot FREE pulses
);

  int outstanding;  // Freed bombs still waiting for their clear

  always_ff @(posedge clk) begin
    if (rst) outstanding <= 0;
    else     outstanding <= outstanding + $countones(free) - int'(clear_req);
  end

  // Ack and drop exclude each other
  a_ack_drop_excl: assert property (@(posedge clk) disable iff (rst)
    !(place_ack && place_drop))
    else $error("place_ack and place_drop high together");

  a_ack_latency: assert property (@(posedge clk) disable iff (rst)
    place_ack |-> $past(place_req))
    else $error("place_ack without a request one cycle earlier");

  // Every request answered on the next cycle
  a_req_answered: assert property (@(posedge clk) disable iff (rst)
    place_req |=> (place_ack || place_drop))
    else $error("placement request left unanswered");

  a_clear_per_free: assert property (@(posedge clk) disable iff (rst)
    clear_req |-> (outstanding > 0))
    else $error("clear_req with no freed bomb behind it");

  // First cycle out of reset is quiet
  a_reset_quiet: assert property (@(posedge clk)
    $fell(rst) |-> !(place_ack || place_drop || clear_req || game_over || exploding))
    else $error("output active in the first cycle after reset");

endmodule

bind bomb_field bomb_field_chk #(.NUM_SLOTS(NUM_SLOTS)) i_chk (
  .clk        (clk),
  .rst        (rst),
  .place_req  (place_req),
  .place_ack  (place_ack),
  .place_drop (place_drop),
  .clear_req  (clear_req),
  .game_over  (game_over),
  .exploding  (exploding),
  .free       (free)
);

/* testbench/tb_bomb_field.sv */
`timescale 1ns/1ps

module tb_bomb_field;

  logic                 clk  = 1'b0;
  logic                 rst;
  logic                 tick = 1'b0;
  logic                 place_req;
  bomb_pkg::tile_addr_t place_addr;
  logic [10:0]          player_x;
  logic [9:0]           player_y;
  logic                 place_ack;
  logic                 place_drop;
  logic                 clear_req;
  bomb_pkg::tile_addr_t clear_addr;
  logic                 game_over;
  logic                 exploding;

  logic [2:0]    tick_cnt;
  int            fd;
  int            budget;                 // Watchdog limit in cycles
  logic          budget_ready = 1'b0;
  logic [63:0]   word;                   // One op token
  logic [1023:0] line;                   // Rest of a pattern line

  bomb_field i_bomb_field (
    .clk        (clk),
    .rst        (rst),
    .tick       (tick),
    .place_req  (place_req),
    .place_addr (place_addr),
    .player_x   (player_x),
    .player_y   (player_y),
    .place_ack  (place_ack),
    .place_drop (place_drop),
    .clear_req  (clear_req),
    .clear_addr (clear_addr),
    .game_over  (game_over),
    .exploding  (exploding)
  );

  always #10 clk = ~clk;  // 20 ns period

  // Time base, one tick every 8 cycles
  always @(posedge clk) begin
    if (rst) begin
      tick_cnt <= '0;
      tick     <= 1'b0;
    end else begin
      tick_cnt <= tick_cnt + 1'b1;
      tick     <= (tick_cnt == 3'd7);
    end
  end

  // -------------------------------------------------------------------------
  // Checking and helpers
  // -------------------------------------------------------------------------
  task automatic check(input int got, input int exp, input string what);
    if (got != exp) begin
      $display("MISMATCH %0t ns: %s, got %0d, expected %0d", $time, what, got, exp);
      $display("RESULT: FAIL");
      $fatal(1, "value check failed");
    end
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("RESULT: FAIL");
    $fatal(1, "run aborted");
  endtask

  task automatic open_patterns();
    fd = $fopen("testbench/bomb_field_patterns.txt", "r");
    if (fd == 0) abort_run("Cannot open testbench/bomb_field_patterns.txt");
  endtask

  // Sum of W counts plus a generous share per waiting op
  task automatic scan_budget();
    int n;
    int cnt;
    budget = 200;  // Margin
    open_patterns();
    n = $fscanf(fd, "%s", word);
    while (n == 1) begin
      if (word[7:0] == "W") begin
        n = $fscanf(fd, "%d", cnt);
        budget += cnt;
      end else if (word[7:0] != "#") begin
        budget += 80;
      end
      n = $fgets(line, fd);
      n = $fscanf(fd, "%s", word);
    end
    $fclose(fd);
    budget_ready = 1'b1;
  endtask

  task automatic place_bomb(input int r, input int c, input int exp);
    @(posedge clk);
    place_req       <= 1'b1;
    place_addr.flat <= {4'(r), 5'(c)};
    @(posedge clk);
    place_req       <= 1'b0;
    @(negedge clk);  // Answer registered on the edge just taken
    check(int'(place_ack), exp, $sformatf("place_ack for tile %0d,%0d", r, c));
    check(int'(place_drop), 1 - exp, $sformatf("place_drop for tile %0d,%0d", r, c));
  endtask

  task automatic move_player(input int x, input int y);
    @(posedge clk);
    player_x <= 11'(x);
    player_y <= 10'(y);
  endtask

  task automatic wait_exploding(input int v);
    @(negedge clk);
    while (int'(exploding) != v) @(negedge clk);
  endtask

  task automatic wait_tick();
    @(negedge clk);
    while (!tick) @(negedge clk);
  endtask

  // Next clear strobe, however late
  task automatic wait_clear(input int r, input int c);
    @(negedge clk);
    while (!clear_req) @(negedge clk);
    check(int'(clear_addr.rc.row), r, "clear_addr row");
    check(int'(clear_addr.rc.col), c, "clear_addr col");
  endtask

  // Clear strobe on the very next cycle
  task automatic next_clear(input int r, input int c);
    @(negedge clk);
    check(int'(clear_req), 1, "back-to-back clear_req");
    check(int'(clear_addr.rc.row), r, "clear_addr row");
    check(int'(clear_addr.rc.col), c, "clear_addr col");
  endtask

  // -------------------------------------------------------------------------
  // Pattern interpreter
  // -------------------------------------------------------------------------
  task automatic run_patterns();
    int n;
    int a;
    int b;
    int e;
    open_patterns();
    n = $fscanf(fd, "%s", word);
    while (n == 1) begin
      case (word[7:0])
        "#": ;                                        // Comment line
        "P": begin
          n = $fscanf(fd, "%d %d %d", a, b, e);
          place_bomb(a, b, e);
        end
        "M": begin
          n = $fscanf(fd, "%d %d", a, b);
          move_player(a, b);
        end
        "W": begin
          n = $fscanf(fd, "%d", a);
          repeat (a) @(posedge clk);
        end
        "E": begin
          n = $fscanf(fd, "%d", e);
          @(negedge clk);
          check(int'(game_over), e, "game_over");
        end
        "X": begin
          n = $fscanf(fd, "%d", e);
          @(negedge clk);
          check(int'(exploding), e, "exploding");
        end
        "B": begin
          n = $fscanf(fd, "%d", e);
          wait_exploding(e);
        end
        "T": wait_tick();
        "C": begin
          n = $fscanf(fd, "%d %d", a, b);
          wait_clear(a, b);
        end
        "N": begin
          n = $fscanf(fd, "%d %d", a, b);
          next_clear(a, b);
        end
        default: abort_run($sformatf("Unknown pattern op %s", word));
      endcase
      n = $fgets(line, fd);
      n = $fscanf(fd, "%s", word);
    end
    $fclose(fd);
  endtask

  // Watchdog
  initial begin
    wait (budget_ready);
    repeat (budget) @(posedge clk);
    abort_run($sformatf("Watchdog expired after %0d cycles, patterns did not finish", budget));
  end

  initial begin
    rst        = 1'b1;
    place_req  = 1'b0;
    place_addr = '0;
    player_x   = '0;
    player_y   = '0;
    scan_budget();
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    run_patterns();
    $display("RESULT: PASS");
    $finish;
  end

endmodule

/* testbench/bomb_field_patterns.txt */
# P row col ack(1)/drop(0) | M px py | W cycles | E game_over | X exploding
# B wait for exploding level | T wait for tick | C row col clear | N row col clear next cycle
X 0
E 0
M 1088 640
# placement rules
P 11 0 0
P 0 19 0
P 2 3 1
P 2 3 0
P 4 4 1
P 6 6 1
P 8 8 1
P 1 1 0
X 0
C 2 3
C 4 4
C 6 6
C 8 8
E 0
# single bomb lifecycle and contact
M 320 320
P 5 5 1
W 4
X 0
E 0
B 1
W 2
E 1
M 384 320
W 2
E 1
M 384 384
W 2
E 0
W 4
X 1
B 0
C 5 5
# straddling sprite, bomb at 5 5, sprite on tile 4 4
M 256 272
P 5 5 1
W 2
E 0
B 1
W 2
E 0
M 256 273
W 2
E 1
M 256 272
W 2
E 0
B 0
C 5 5
# two bombs in one tick period, then slot reuse
M 1088 640
T
P 1 1 1
P 1 3 1
C 1 1
N 1 3
P 7 7 1
P 7 9 1
C 7 7
C 7 9
# map edge
M 0 256
P 3 18 1
B 1
W 2
E 0
M 1088 192
W 2
E 1
M 1088 640
B 0
C 3 18
E 0

/* bomb_blast.f */
common/bomb_pkg.sv
bomb/bomb_dispatch.sv
bomb/bomb_slot.sv
bomb/blast_collect.sv
logic/bomb_field.sv
testbench/bomb_field_chk.sv
testbench/tb_bomb_field.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the bomb subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f bomb_blast.f \
  --top-module tb_bomb_field \
  -o sim_bomb_field
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

./obj_dir/sim_bomb_field
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit $status
fi

echo "Simulation completed"
exit 0
